/* design/w8_pkg.sv */
package w8_pkg;

  // ************************************************************
  // Data widths
  // ************************************************************
  localparam int DATA_W = 16;                 // Q1.15 component.
  localparam int PROD_W = 32;                 // Shift-and-add accumulator.
  localparam int OUT_W  = DATA_W + 1;         // One guard bit for sum/difference.

  // ************************************************************
  // 1/sqrt(2) as 2896/4096
  // ************************************************************
  localparam int HALF_SQRT2_NUM = 2896;
  localparam int FRAC_SHIFT     = 12;

  // 2^4 + 2^6 + 2^8 + 2^9 + 2^11 = 2896
  localparam int SHIFT_A = 4;
  localparam int SHIFT_B = 6;
  localparam int SHIFT_C = 8;
  localparam int SHIFT_D = 9;
  localparam int SHIFT_E = 11;

  localparam int MAX_PROD_MAG = 23168;        // floor(32768 * 2896 / 4096).

  localparam int MULT_LATENCY = 1;            // Cycles through halfsqrt2_mult.
  localparam int COMB_LATENCY = 1;            // Cycles through w8_rotate_combine.

endpackage

/* design/ksa_adder.sv */
`timescale 1ns/1ps

module ksa_adder #(
  parameter int DATA_WIDTH = 32
) (
  input  logic [DATA_WIDTH-1:0] i_a,
  input  logic [DATA_WIDTH-1:0] i_b,
  input  logic                  i_c0,
  output logic [DATA_WIDTH-1:0] o_s,
  output logic                  o_carry
);

  localparam int LEVELS = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] gen_bit;
  logic [DATA_WIDTH-1:0] prop_bit;

  // Group generate/propagate per prefix level, level 0 is the bitwise pair.
  logic [DATA_WIDTH-1:0] grp_g [0:LEVELS];
  logic [DATA_WIDTH-1:0] grp_p [0:LEVELS];

  // ************************************************************
  // Bitwise generate and propagate
  // ************************************************************
  assign gen_bit  = i_a & i_b;
  assign prop_bit = i_a ^ i_b;

  // Carry in is folded into bit 0 so the prefix tree needs no extra column.
  assign grp_g[0] = {gen_bit[DATA_WIDTH-1:1], gen_bit[0] | (prop_bit[0] & i_c0)};
  assign grp_p[0] = prop_bit;

  // ************************************************************
  // Kogge-Stone prefix levels
  // ************************************************************
  for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
    localparam int SPAN = 1 << (lvl - 1);    // Distance doubles per level.

    for (genvar bit_i = 0; bit_i < DATA_WIDTH; bit_i++) begin : g_bit
      if (bit_i >= SPAN) begin : g_merge
        assign grp_g[lvl][bit_i] = grp_g[lvl-1][bit_i] |
                                   (grp_p[lvl-1][bit_i] & grp_g[lvl-1][bit_i-SPAN]);
        assign grp_p[lvl][bit_i] = grp_p[lvl-1][bit_i] & grp_p[lvl-1][bit_i-SPAN];
      end else begin : g_pass
        assign grp_g[lvl][bit_i] = grp_g[lvl-1][bit_i];   // Already resolved.
        assign grp_p[lvl][bit_i] = grp_p[lvl-1][bit_i];
      end
    end
  end

  // ************************************************************
  // Sum and carry out
  // ************************************************************
  // Carry into bit i is the group generate of bits i-1 down to 0.
  assign o_s     = prop_bit ^ {grp_g[LEVELS][DATA_WIDTH-2:0], i_c0};
  assign o_carry = grp_g[LEVELS][DATA_WIDTH-1];

endmodule

/* design/halfsqrt2_mult.sv */
`timescale 1ns/1ps

module halfsqrt2_mult (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  input  logic                               i_valid,
  input  logic signed [w8_pkg::DATA_W-1:0]   i_data,
  output logic                               o_valid,
  output logic signed [w8_pkg::DATA_W-1:0]   o_data
);

  import w8_pkg::*;

  localparam int SHIFT_SUM = (1 << SHIFT_A) + (1 << SHIFT_B) + (1 << SHIFT_C) +
                             (1 << SHIFT_D) + (1 << SHIFT_E);

  if (SHIFT_SUM != HALF_SQRT2_NUM) begin : g_const_check
    $error("halfsqrt2_mult: shift positions do not sum to the constant");
  end

  logic                in_neg;
  logic [DATA_W-1:0]   in_mag;
  logic [PROD_W-1:0]   mag_ext;
  logic [PROD_W-1:0]   term_a;
  logic [PROD_W-1:0]   term_b;
  logic [PROD_W-1:0]   term_c;
  logic [PROD_W-1:0]   term_d;
  logic [PROD_W-1:0]   term_e;
  logic [PROD_W-1:0]   sum_bc;
  logic [PROD_W-1:0]   sum_de;
  logic [PROD_W-1:0]   sum_abc;
  logic [PROD_W-1:0]   sum_all;
  logic [DATA_W-1:0]   prod_mag;
  logic [DATA_W-1:0]   prod_signed;

  // ************************************************************
  // Sign-magnitude split
  // ************************************************************
  assign in_neg  = i_data[DATA_W-1];
  assign in_mag  = in_neg ? (~i_data + 1'b1) : i_data;    // -32768 gives 0x8000.
  assign mag_ext = {{(PROD_W-DATA_W){1'b0}}, in_mag};

  assign term_a = mag_ext << SHIFT_A;
  assign term_b = mag_ext << SHIFT_B;
  assign term_c = mag_ext << SHIFT_C;
  assign term_d = mag_ext << SHIFT_D;
  assign term_e = mag_ext << SHIFT_E;

  // ************************************************************
  // Shift-and-add tree
  // ************************************************************
  ksa_adder #(.DATA_WIDTH(PROD_W)) u_add_bc (
    .i_a(term_b), .i_b(term_c), .i_c0(1'b0), .o_s(sum_bc), .o_carry()
  );

  ksa_adder #(.DATA_WIDTH(PROD_W)) u_add_de (
    .i_a(term_d), .i_b(term_e), .i_c0(1'b0), .o_s(sum_de), .o_carry()
  );

  ksa_adder #(.DATA_WIDTH(PROD_W)) u_add_abc (
    .i_a(term_a), .i_b(sum_bc), .i_c0(1'b0), .o_s(sum_abc), .o_carry()
  );

  ksa_adder #(.DATA_WIDTH(PROD_W)) u_add_all (
    .i_a(sum_de), .i_b(sum_abc), .i_c0(1'b0), .o_s(sum_all), .o_carry()
  );

  // Drop the 12 fraction bits of the constant, truncating.
  assign prod_mag    = sum_all[FRAC_SHIFT+DATA_W-1:FRAC_SHIFT];
  assign prod_signed = in_neg ? (~prod_mag + 1'b1) : prod_mag;

  // ************************************************************
  // Output register
  // ************************************************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_data  <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_data <= prod_signed;                 // Hold between samples.
      end
    end
  end

  a_prod_bound : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid |-> (o_data <= MAX_PROD_MAG) && (o_data >= -MAX_PROD_MAG))
    else $error("halfsqrt2_mult: product magnitude above bound");

endmodule

/* design/w8_rotate_combine.sv */
`timescale 1ns/1ps

module w8_rotate_combine (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  input  logic                               i_valid_re,
  input  logic                               i_valid_im,
  input  logic signed [w8_pkg::DATA_W-1:0]   i_prod_re,
  input  logic signed [w8_pkg::DATA_W-1:0]   i_prod_im,
  output logic                               o_valid,
  output logic signed [w8_pkg::OUT_W-1:0]    o_re,
  output logic signed [w8_pkg::OUT_W-1:0]    o_im
);

  import w8_pkg::*;

  logic                pair_valid;
  logic [OUT_W-1:0]    ext_re;
  logic [OUT_W-1:0]    ext_im;
  logic [OUT_W-1:0]    sum_ri;
  logic [OUT_W-1:0]    diff_ir;

  assign pair_valid = i_valid_re & i_valid_im;

  assign ext_re = {i_prod_re[DATA_W-1], i_prod_re};   // Sign extend.
  assign ext_im = {i_prod_im[DATA_W-1], i_prod_im};

  // re + im
  ksa_adder #(.DATA_WIDTH(OUT_W)) u_add_sum (
    .i_a(ext_re), .i_b(ext_im), .i_c0(1'b0), .o_s(sum_ri), .o_carry()
  );

  // im - re as im + ~re + 1.
  ksa_adder #(.DATA_WIDTH(OUT_W)) u_add_diff (
    .i_a(ext_im), .i_b(~ext_re), .i_c0(1'b1), .o_s(diff_ir), .o_carry()
  );

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_re    <= '0;
      o_im    <= '0;
    end else begin
      o_valid <= pair_valid;
      if (pair_valid) begin
        o_re <= sum_ri;
        o_im <= diff_ir;
      end
    end
  end

  // ************************************************************
  // Checks
  // ************************************************************
  // Both multipliers run in lockstep.
  a_valid_pair : assert property (@(posedge i_clk) i_valid_re == i_valid_im)
    else $error("w8_rotate_combine: multiplier valids out of step");

  a_reset_quiet : assert property (@(posedge i_clk) !i_arst_n |-> !o_valid)
    else $error("w8_rotate_combine: o_valid high in reset");

endmodule

/* design/w8_twiddle_top.sv */
`timescale 1ns/1ps

module w8_twiddle_top (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  input  logic                               i_valid,
  input  logic signed [w8_pkg::DATA_W-1:0]   i_re,
  input  logic signed [w8_pkg::DATA_W-1:0]   i_im,
  output logic                               o_valid,
  output logic signed [w8_pkg::OUT_W-1:0]    o_re,
  output logic signed [w8_pkg::OUT_W-1:0]    o_im
);

  import w8_pkg::*;

  logic                       valid_re;
  logic                       valid_im;
  logic signed [DATA_W-1:0]   prod_re;    // f(re).
  logic signed [DATA_W-1:0]   prod_im;    // f(im).

  halfsqrt2_mult u_mult_re (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_valid(i_valid), .i_data(i_re),
    .o_valid(valid_re), .o_data(prod_re)
  );

  halfsqrt2_mult u_mult_im (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_valid(i_valid), .i_data(i_im),
    .o_valid(valid_im), .o_data(prod_im)
  );

  w8_rotate_combine u_combine (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_valid_re(valid_re), .i_valid_im(valid_im),
    .i_prod_re(prod_re), .i_prod_im(prod_im),
    .o_valid(o_valid), .o_re(o_re), .o_im(o_im)
  );

endmodule

/* tests/tb_w8_twiddle.sv */
`timescale 1ns/1ps

module tb_w8_twiddle;

  import w8_pkg::*;

  localparam int REF_NUM       = 2896;        // 1/sqrt(2) in units of 1/4096.
  localparam int REF_DEN       = 4096;
  localparam int DRAIN_TIMEOUT = 50;
  localparam int RANDOM_COUNT  = 200;
  localparam int GAP_COUNT     = 100;

  logic                     i_clk = 1'b0;
  logic                     i_arst_n;
  logic                     i_valid;
  logic signed [DATA_W-1:0] i_re;
  logic signed [DATA_W-1:0] i_im;
  logic                     o_valid;
  logic signed [OUT_W-1:0]  o_re;
  logic signed [OUT_W-1:0]  o_im;

  logic signed [OUT_W-1:0]  exp_re;             // Reference for the current inputs.
  logic signed [OUT_W-1:0]  exp_im;

  integer seed;
  int     err_count      = 0;
  int     phase_err_base = 0;
  int     pass_count     = 0;
  int     fail_count     = 0;
  int     sent_count     = 0;
  int     out_count      = 0;

  w8_twiddle_top uut (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_valid(i_valid), .i_re(i_re), .i_im(i_im),
    .o_valid(o_valid), .o_re(o_re), .o_im(o_im)
  );

  always #2 i_clk = ~i_clk;

  // ************************************************************
  // Reference model
  // ************************************************************
  // sign(x) * floor(|x| * 2896 / 4096), magnitude taken in 32 bits.
  function automatic int scale_half_sqrt2(input logic signed [DATA_W-1:0] x);
    int mag;
    int prod;
    mag  = (x < 0) ? -int'(x) : int'(x);
    prod = (mag * REF_NUM) / REF_DEN;
    return (x < 0) ? -prod : prod;
  endfunction

  always_comb begin
    exp_re = OUT_W'(scale_half_sqrt2(i_re) + scale_half_sqrt2(i_im));
    exp_im = OUT_W'(scale_half_sqrt2(i_im) - scale_half_sqrt2(i_re));
  end

  // ************************************************************
  // Checks
  // ************************************************************
  a_reset_quiet : assert property (@(posedge i_clk) !i_arst_n |-> !o_valid)
    else begin
      err_count++;
      $display("Fail %0t: o_valid high during reset", $time);
    end

  a_latency : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid == $past(i_valid, 2))
    else begin
      err_count++;
      $display("Fail %0t: o_valid=%0b is not i_valid delayed by two cycles",
               $time, $sampled(o_valid));
    end

  a_data : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid |-> (o_re == $past(exp_re, 2)) && (o_im == $past(exp_im, 2)))
    else begin
      err_count++;
      $display("Fail %0t: output (%0d, %0d) does not match the reference",
               $time, $sampled(o_re), $sampled(o_im));
    end

  a_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !o_valid |-> (o_re == $past(o_re)) && (o_im == $past(o_im)))
    else begin
      err_count++;
      $display("Fail %0t: output changed while o_valid was low", $time);
    end

  always @(posedge i_clk) begin
    if (i_arst_n && o_valid) begin
      out_count <= out_count + 1;
    end
  end

  // ************************************************************
  // Stimulus helpers
  // ************************************************************
  function automatic logic [DATA_W-1:0] next_random();
    return DATA_W'($random(seed));
  endfunction

  task automatic send_sample(input logic valid, input logic signed [DATA_W-1:0] re,
                             input logic signed [DATA_W-1:0] im);
    @(posedge i_clk);
    i_valid <= valid;
    i_re    <= re;
    i_im    <= im;
    if (valid) begin
      sent_count++;
    end
  endtask

  task automatic wait_drain(input string phase_name);
    int cycles;
    cycles = 0;
    send_sample(1'b0, next_random(), next_random());
    while (out_count < sent_count && cycles < DRAIN_TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
    end
    if (out_count < sent_count) begin
      $display("o_valid never arrived for the last sample of the %s phase.", phase_name);
      $display("TEST FAIL");
      $finish;
    end
  endtask

  task automatic report_phase(input string phase_name);
    int phase_errs;
    @(posedge i_clk);                         // Let the last checks settle.
    phase_errs     = err_count - phase_err_base;
    phase_err_base = err_count;
    if (phase_errs == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("Phase %s done with %0d errors", phase_name, phase_errs);
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************
  initial begin
    logic signed [DATA_W-1:0] corner [0:5];
    logic [23:0]              pattern;
    int                       gap;
    corner  = '{16'h8000, 16'h7fff, 16'h0000, 16'h0001, 16'hffff, 16'd2896};
    pattern = 24'b1101_0011_1110_0100_0111_0101;   // Singles and bursts.
    seed    = 32'he9569d57;
    i_arst_n <= 1'b0;
    i_valid  <= 1'b0;
    i_re     <= '0;
    i_im     <= '0;

    // A sample offered in reset must not leak out.
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_re    <= next_random();
    i_im    <= next_random();
    repeat (3) send_sample(1'b0, next_random(), next_random());
    i_arst_n <= 1'b1;
    repeat (3) send_sample(1'b0, next_random(), next_random());
    report_phase("reset");

    for (int k = 0; k < 24; k++) begin
      send_sample(pattern[k], next_random(), next_random());
    end
    wait_drain("latency");
    report_phase("latency");

    for (int a = 0; a < 6; a++) begin
      for (int b = 0; b < 6; b++) begin
        send_sample(1'b1, corner[a], corner[b]);
      end
    end
    wait_drain("corner");
    report_phase("corner");

    for (int k = 0; k < RANDOM_COUNT; k++) begin
      send_sample(1'b1, next_random(), next_random());
    end
    wait_drain("random");
    report_phase("random");

    for (int k = 0; k < GAP_COUNT; k++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) send_sample(1'b0, next_random(), next_random());
      send_sample(1'b1, next_random(), next_random());
    end
    wait_drain("holding");
    report_phase("holding");

    $display("Phases passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
design/w8_pkg.sv
design/ksa_adder.sv
design/halfsqrt2_mult.sv
design/w8_rotate_combine.sv
design/w8_twiddle_top.sv
tests/tb_w8_twiddle.sv

/* run_sim.sh */
#!/bin/sh
# Build the W8 twiddle testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_w8_twiddle \
  -o sim_w8_twiddle > build.log 2>&1 &&
  ./obj_dir/sim_w8_twiddle > sim.log 2>&1 ||
  { echo "Build or simulation failed"; cat build.log; [ -f sim.log ] && cat sim.log; exit 1; }

grep -q "^TEST PASS$" sim.log &&
  { cat sim.log; exit 0; } ||
  { cat sim.log; exit 1; }
